/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int data_width     = 32;
    localparam int reg_count      = 16;
    localparam int reg_addr_width = 4;
    localparam int imm_width      = 19;  // rc field plus the 15-bit tail

    typedef enum logic [2:0] {
        st_t1, st_t2, st_t3, st_t4, st_t5
    } stage_t;

    typedef enum logic [4:0] {
        op_add  = 5'b00011,
        op_sub  = 5'b00100,
        op_and  = 5'b00101,
        op_or   = 5'b00110,
        op_rotr = 5'b00111,
        op_rotl = 5'b01000,
        op_shr  = 5'b01001,
        op_shra = 5'b01010,
        op_shl  = 5'b01011,
        op_addi = 5'b01100,
        op_andi = 5'b01101,
        op_ori  = 5'b01110,
        op_div  = 5'b01111,
        op_mul  = 5'b10000,
        op_neg  = 5'b10001,
        op_not  = 5'b10010,
        op_mflo = 5'b11000,
        op_mfhi = 5'b11001
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_rotr, alu_rotl,
        alu_shr, alu_shra, alu_shl, alu_neg, alu_not
    } alu_op_t;

    typedef enum logic [1:0] { md_none, md_mul, md_div } muldiv_op_t;

    typedef enum logic [1:0] { y_alu, y_hi, y_lo } y_sel_t;

    typedef struct packed {
        opcode_t                   op;
        logic [reg_addr_width-1:0] ra;    // destination
        logic [reg_addr_width-1:0] rb;    // first source
        logic [reg_addr_width-1:0] rc;    // second source, or top of the immediate
        logic [14:0]               tail;
    } instr_t;

    typedef struct packed {
        alu_op_t                   alu_op;
        muldiv_op_t                muldiv_op;
        y_sel_t                    y_sel;
        logic                      src2_imm;
        logic [reg_addr_width-1:0] dst;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [data_width-1:0]     imm;          // already sign-extended
        logic                      operand_load; // T2
        logic                      result_load;  // T3
        logic                      wb_cycle;     // T5, every instruction retires here
        logic                      rf_write;
        logic                      hilo_write;
    } ctrl_t;

    typedef struct packed {
        logic [data_width-1:0] hi;
        logic [data_width-1:0] lo;
    } hilo_t;

    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [reg_addr_width-1:0] dst;
        logic [data_width-1:0]     data;
    } retire_t;

endpackage

`default_nettype wire

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire cpu_pkg::instr_t instr,
    output logic                 instr_load,
    output cpu_pkg::ctrl_t       ctrl
);

    cpu_pkg::stage_t stage;
    cpu_pkg::instr_t ir;
    logic            legal_op;
    logic            writes_hilo;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            stage <= cpu_pkg::st_t1;
        else
        begin
            case (stage)
                cpu_pkg::st_t1: stage <= cpu_pkg::st_t2;
                cpu_pkg::st_t2: stage <= cpu_pkg::st_t3;
                cpu_pkg::st_t3: stage <= cpu_pkg::st_t4;
                cpu_pkg::st_t4: stage <= cpu_pkg::st_t5;  // memory slot, unused
                default:        stage <= cpu_pkg::st_t1;
            endcase
        end
    end

    assign instr_load = (stage == cpu_pkg::st_t1);

    always_ff @(posedge clock)
    begin
        if (instr_load)
            ir <= instr;
    end

    always_comb
    begin
        ctrl        = '0;
        legal_op    = 1'b1;
        ctrl.dst    = ir.ra;
        ctrl.src_a  = ir.rb;
        ctrl.src_b  = ir.rc;
        ctrl.imm    = {{(cpu_pkg::data_width - cpu_pkg::imm_width){ir.rc[3]}}, ir.rc, ir.tail};
        ctrl.src2_imm = ir.op inside {cpu_pkg::op_addi, cpu_pkg::op_andi, cpu_pkg::op_ori};
        case (ir.op)
            cpu_pkg::op_add, cpu_pkg::op_addi: ctrl.alu_op = cpu_pkg::alu_add;
            cpu_pkg::op_sub:                   ctrl.alu_op = cpu_pkg::alu_sub;
            cpu_pkg::op_and, cpu_pkg::op_andi: ctrl.alu_op = cpu_pkg::alu_and;
            cpu_pkg::op_or, cpu_pkg::op_ori:   ctrl.alu_op = cpu_pkg::alu_or;
            cpu_pkg::op_rotr:                  ctrl.alu_op = cpu_pkg::alu_rotr;
            cpu_pkg::op_rotl:                  ctrl.alu_op = cpu_pkg::alu_rotl;
            cpu_pkg::op_shr:                   ctrl.alu_op = cpu_pkg::alu_shr;
            cpu_pkg::op_shra:                  ctrl.alu_op = cpu_pkg::alu_shra;
            cpu_pkg::op_shl:                   ctrl.alu_op = cpu_pkg::alu_shl;
            cpu_pkg::op_neg:                   ctrl.alu_op = cpu_pkg::alu_neg;
            cpu_pkg::op_not:                   ctrl.alu_op = cpu_pkg::alu_not;
            cpu_pkg::op_mul:                   ctrl.muldiv_op = cpu_pkg::md_mul;
            cpu_pkg::op_div:                   ctrl.muldiv_op = cpu_pkg::md_div;
            cpu_pkg::op_mfhi:                  ctrl.y_sel = cpu_pkg::y_hi;
            cpu_pkg::op_mflo:                  ctrl.y_sel = cpu_pkg::y_lo;
            default:                           legal_op = 1'b0;  // retires as a no-op
        endcase
        writes_hilo = (ctrl.muldiv_op != cpu_pkg::md_none);

        ctrl.operand_load = (stage == cpu_pkg::st_t2);
        ctrl.result_load  = (stage == cpu_pkg::st_t3);
        ctrl.wb_cycle     = (stage == cpu_pkg::st_t5);
        ctrl.rf_write     = ctrl.wb_cycle && legal_op && !writes_hilo;
        ctrl.hilo_write   = ctrl.wb_cycle && writes_hilo;
    end

    // any write closes a pass that started with a load four cycles back
    a_write_after_load: assert property (@(posedge clock) disable iff (!rst_n)
        (ctrl.rf_write || ctrl.hilo_write) |-> $past(instr_load, 4));

    // results are taken the cycle after the operands, never alongside them
    a_operand_then_result: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl.operand_load |-> !ctrl.result_load ##1 (ctrl.result_load && !ctrl.operand_load));

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                           clock,
    input  wire logic [cpu_pkg::data_width-1:0] a,
    input  wire logic [cpu_pkg::data_width-1:0] b,
    input  wire cpu_pkg::alu_op_t               alu_op,
    input  wire logic                           result_load,
    output logic      [cpu_pkg::data_width-1:0] rz
);

    logic [4:0]                         sh;
    logic [2*cpu_pkg::data_width-1:0]   rot_r;
    logic [2*cpu_pkg::data_width-1:0]   rot_l;
    logic [cpu_pkg::data_width-1:0]     result;

    assign sh    = b[4:0];          // only the low 5 bits count
    assign rot_r = {a, a} >> sh;    // low half is a rotated right
    assign rot_l = {a, a} << sh;    // high half is a rotated left

    always_comb
    begin
        case (alu_op)
            cpu_pkg::alu_add:  result = a + b;
            cpu_pkg::alu_sub:  result = a - b;
            cpu_pkg::alu_and:  result = a & b;
            cpu_pkg::alu_or:   result = a | b;
            cpu_pkg::alu_rotr: result = rot_r[cpu_pkg::data_width-1:0];
            cpu_pkg::alu_rotl: result = rot_l[2*cpu_pkg::data_width-1:cpu_pkg::data_width];
            cpu_pkg::alu_shr:  result = a >> sh;
            cpu_pkg::alu_shra: result = $signed(a) >>> sh;
            cpu_pkg::alu_shl:  result = a << sh;
            cpu_pkg::alu_neg:  result = '0 - b;
            cpu_pkg::alu_not:  result = ~b;
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (result_load)
            rz <= result;  // held until the next T3
    end

endmodule

`default_nettype wire

/* rtl/mul_div.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_div (
    input  wire logic                           clock,
    input  wire logic [cpu_pkg::data_width-1:0] a,
    input  wire logic [cpu_pkg::data_width-1:0] b,
    input  wire cpu_pkg::muldiv_op_t            muldiv_op,
    input  wire logic                           result_load,
    input  wire logic                           hilo_write,
    output cpu_pkg::hilo_t                      product
);

    logic signed [2*cpu_pkg::data_width-1:0] prod_full;
    cpu_pkg::hilo_t                          result;

    assign prod_full = $signed(a) * $signed(b);

    always_comb
    begin
        result = '0;
        case (muldiv_op)
            cpu_pkg::md_mul: result = prod_full;  // hi takes the upper half
            cpu_pkg::md_div:
            begin
                if (b == '0)
                begin
                    result.lo = '1;  // no trap on divide by zero
                    result.hi = a;
                end
                else
                begin
                    result.lo = $signed(a) / $signed(b);
                    result.hi = $signed(a) % $signed(b);
                end
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (result_load)
            product <= result;
    end

    // hi/lo only take a mul or div result that was registered two cycles before
    a_hilo_source: assert property (@(posedge clock)
        $rose(hilo_write) |-> (muldiv_op != cpu_pkg::md_none) && $past(result_load, 2));

endmodule

`default_nettype wire

/* rtl/register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire logic                           clock,
    input  wire logic                           rst_n,
    input  wire cpu_pkg::ctrl_t                 ctrl,
    input  wire logic [cpu_pkg::data_width-1:0] rz,
    input  wire cpu_pkg::hilo_t                 product,
    output logic      [cpu_pkg::data_width-1:0] a,
    output logic      [cpu_pkg::data_width-1:0] b,
    output cpu_pkg::retire_t                    retire
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];
    logic [cpu_pkg::data_width-1:0] hi;
    logic [cpu_pkg::data_width-1:0] lo;
    logic [cpu_pkg::data_width-1:0] y;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::reg_count; i++)
                regs[i] <= '0;
            hi <= '0;
            lo <= '0;
        end
        else
        begin
            if (ctrl.rf_write)
                regs[ctrl.dst] <= y;
            if (ctrl.hilo_write)
            begin
                hi <= product.hi;
                lo <= product.lo;
            end
        end
    end

    // operand latches, loaded in T2
    always_ff @(posedge clock)
    begin
        if (ctrl.operand_load)
        begin
            a <= regs[ctrl.src_a];
            b <= ctrl.src2_imm ? ctrl.imm : regs[ctrl.src_b];
        end
    end

    always_comb
    begin
        case (ctrl.y_sel)
            cpu_pkg::y_hi: y = hi;
            cpu_pkg::y_lo: y = lo;
            default:       y = rz;
        endcase
    end

    always_comb
    begin
        retire.valid = ctrl.wb_cycle;
        retire.write = ctrl.rf_write;
        retire.dst   = ctrl.dst;
        retire.data  = y;  // value written on this edge when write is set
    end

    // one retire per pass, three cycles after the operand latch
    a_single_retire: assert property (@(posedge clock) disable iff (!rst_n)
        retire.valid |-> $past(ctrl.operand_load, 3) ##1 !retire.valid);

endmodule

`default_nettype wire

/* rtl/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire cpu_pkg::instr_t instr,
    output logic                 instr_load,
    output cpu_pkg::retire_t     retire
);

    cpu_pkg::ctrl_t                 ctrl;
    logic [cpu_pkg::data_width-1:0] a;
    logic [cpu_pkg::data_width-1:0] b;
    logic [cpu_pkg::data_width-1:0] rz;
    cpu_pkg::hilo_t                 product;

    control_unit i_control_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .instr      (instr),
        .instr_load (instr_load),
        .ctrl       (ctrl)
    );

    alu i_alu (
        .clock       (clock),
        .a           (a),
        .b           (b),
        .alu_op      (ctrl.alu_op),
        .result_load (ctrl.result_load),
        .rz          (rz)
    );

    mul_div i_mul_div (
        .clock       (clock),
        .a           (a),
        .b           (b),
        .muldiv_op   (ctrl.muldiv_op),
        .result_load (ctrl.result_load),
        .hilo_write  (ctrl.hilo_write),
        .product     (product)
    );

    register_bank i_register_bank (
        .clock   (clock),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .rz      (rz),
        .product (product),
        .a       (a),
        .b       (b),
        .retire  (retire)
    );

endmodule

`default_nettype wire

/* bench/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

    logic             clock = 1'b0;
    logic             rst_n;
    cpu_pkg::instr_t  instr;
    logic             instr_load;
    cpu_pkg::retire_t retire;

    logic [15:0] lfsr;
    logic [31:0] m_regs [16];  // reference register file
    logic [31:0] m_hi;
    logic [31:0] m_lo;
    logic [31:0] follow_ups [$];  // mfhi/mflo queued after a mul or div
    int          cycle_count = 0;
    int          last_retire = -1;

    exec_core i_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .instr      (instr),
        .instr_load (instr_load),
        .retire     (retire)
    );

    always #4 clock = ~clock;

    always @(posedge clock)
        cycle_count <= cycle_count + 1;

    // 16-bit fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // expected retire of one instruction, then the model state update
    task automatic model_step(input logic [31:0] word, output logic exp_write,
                              output logic [31:0] exp_data);
        logic [4:0]         op;
        logic [4:0]         s;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        imm;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] p;
        op  = word[31:27];
        a   = m_regs[word[22:19]];
        b   = m_regs[word[18:15]];
        imm = {{13{word[18]}}, word[18:0]};  // 19-bit immediate, sign-extended
        s   = b[4:0];
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        exp_write = 1'b1;
        exp_data  = '0;
        case (op)
            cpu_pkg::op_add:  exp_data = a + b;
            cpu_pkg::op_sub:  exp_data = a - b;
            cpu_pkg::op_and:  exp_data = a & b;
            cpu_pkg::op_or:   exp_data = a | b;
            cpu_pkg::op_rotr: exp_data = (a >> s) | (a << (32 - s));
            cpu_pkg::op_rotl: exp_data = (a << s) | (a >> (32 - s));
            cpu_pkg::op_shr:  exp_data = a >> s;
            cpu_pkg::op_shra: exp_data = $signed(a) >>> s;
            cpu_pkg::op_shl:  exp_data = a << s;
            cpu_pkg::op_addi: exp_data = a + imm;
            cpu_pkg::op_andi: exp_data = a & imm;
            cpu_pkg::op_ori:  exp_data = a | imm;
            cpu_pkg::op_neg:  exp_data = 32'd0 - b;
            cpu_pkg::op_not:  exp_data = ~b;
            cpu_pkg::op_mfhi: exp_data = m_hi;
            cpu_pkg::op_mflo: exp_data = m_lo;
            cpu_pkg::op_mul:
            begin
                exp_write = 1'b0;
                p    = sa * sb;
                m_hi = p[63:32];
                m_lo = p[31:0];
            end
            cpu_pkg::op_div:
            begin
                exp_write = 1'b0;
                if (b == 32'd0)
                begin
                    m_lo = '1;
                    m_hi = a;
                end
                else
                begin
                    p    = sa / sb;  // 64-bit math keeps the min / -1 case defined
                    m_lo = p[31:0];
                    p    = sa % sb;
                    m_hi = p[31:0];
                end
            end
            default:          exp_write = 1'b0;  // unlisted, no-op
        endcase
        if (exp_write)
            m_regs[word[26:23]] = exp_data;
    endtask

    task automatic make_random_instr(output logic [31:0] word);
        logic [31:0] r;
        logic [31:0] code;
        logic [31:0] fields;
        logic [3:0]  dst;
        r = take_bits(5);
        if (r >= 29)
        begin
            r    = take_bits(2);
            code = (r == 0) ? 0 : (r == 1) ? 2 : (r == 2) ? 21 : 30;  // unlisted codes
        end
        else
        begin
            if (r >= 18)
                r = r - 18;
            code = (r < 16) ? r + 3 : r + 8;  // 3..18, then mflo and mfhi
        end
        fields = take_bits(27);
        if (fields[26:23] == 4'd0)
            fields[26:23] = 4'd1;  // r0 stays zero
        if (code[4:0] == cpu_pkg::op_div)
        begin
            r = take_bits(3);
            if (r == 0)
                fields[18:15] = 4'd0;  // divide by zero
        end
        word = {code[4:0], fields[26:0]};
        if (code[4:0] == cpu_pkg::op_mul || code[4:0] == cpu_pkg::op_div)
        begin
            r   = take_bits(4);
            dst = (r[3:1] == 3'd0) ? 4'd2 : r[3:0];  // keeps dst ^ 1 off r0
            follow_ups.push_back({cpu_pkg::op_mfhi, dst, 8'd0, 15'd0});
            follow_ups.push_back({cpu_pkg::op_mflo, dst ^ 4'd1, 8'd0, 15'd0});
        end
    endtask

    // load one instruction in T1 and check its retire in T5
    task automatic run_instr(input logic [31:0] word);
        int          waited;
        int          load_cycle;
        logic        exp_write;
        logic [31:0] exp_data;
        waited = 0;
        while (!instr_load)
        begin
            @(negedge clock);
            waited++;
            if (waited > 10)
            begin
                $display("Timeout: instr_load never went high");
                abort_run();
            end
        end
        instr      = cpu_pkg::instr_t'(word);
        load_cycle = cycle_count;
        @(negedge clock);
        waited = 0;
        while (!retire.valid)
        begin
            @(negedge clock);
            waited++;
            if (waited > 10)
            begin
                $display("Timeout: retire.valid never went high");
                abort_run();
            end
        end
        model_step(word, exp_write, exp_data);
        check_value("load to retire cycles", cycle_count - load_cycle, 4);  // T1 to T5
        if (last_retire >= 0)
            check_value("retire spacing", cycle_count - last_retire, 5);
        last_retire = cycle_count;
        check_value("instr_load in T5", {31'd0, instr_load}, 32'd0);
        check_value("retire.write", {31'd0, retire.write}, {31'd0, exp_write});
        if (exp_write)
        begin
            check_value("retire.dst", {28'd0, retire.dst}, {28'd0, word[26:23]});
            check_value("retire.data", retire.data, exp_data);
        end
        @(negedge clock);
    endtask

    initial
    begin
        logic [31:0] word;
        rst_n = 1'b0;
        instr = '0;
        lfsr  = 16'd26146;
        m_hi  = '0;
        m_lo  = '0;
        for (int i = 0; i < 16; i++)
            m_regs[i] = '0;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        check_value("instr_load after reset", {31'd0, instr_load}, 32'd1);
        check_value("retire.valid after reset", {31'd0, retire.valid}, 32'd0);
        for (int n = 0; n < 400 || follow_ups.size() > 0; n++)
        begin
            if (follow_ups.size() > 0)
                word = follow_ups.pop_front();
            else
                make_random_instr(word);
            run_instr(word);
        end
        // read back every register through add with r0
        for (int r = 0; r < 16; r++)
            run_instr({cpu_pkg::op_add, r[3:0], r[3:0], 4'd0, 15'd0});
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/mul_div.sv
rtl/register_bank.sv
rtl/exec_core.sv
bench/tb_exec_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_exec_core \
    -f project.f -Mdir obj_dir \
    && ./obj_dir/Vtb_exec_core | tee sim.log
grep -q "Result: PASSED" sim.log && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
